// ==== tl_ul_slave_top.f ====
+incdir+sim
logic/tl_ul_pkg.sv
logic/tl_slave_fsm.sv
logic/tl_request_decode.sv
logic/tl_byte_mem.sv
logic/tl_ul_slave_top.sv
sim/tl_ul_slave_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the TL-UL slave testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tl_ul_slave_tb \
	-f tl_ul_slave_top.f -o tl_ul_slave_sim > build.log 2>&1 \
	&& ./obj_dir/tl_ul_slave_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "TEST OK" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sim/tl_ul_slave_tasks.svh ====
`ifndef TL_UL_SLAVE_TASKS_SVH
`define TL_UL_SLAVE_TASKS_SVH

//////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////

// 32-bit LCG, full period mod 2^32
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// Upper bits only, the low ones cycle fast
function automatic int rand_below(input int n);
	logic [31:0] r;
	r = lcg_next();
	return int'(r[31:16]) % n;
endfunction

task automatic check_value(input string name, input logic [63:0] expected,
	input logic [63:0] actual);
	if (actual !== expected) begin
		$display("Mismatch %s expected %h actual %h", name, expected, actual);
		fail_count++;
	end else begin
		pass_count++;
	end
endtask

task automatic report_failure(input string what);
	$display("Error: %s", what);
	fail_count++;
endtask

//////////////////////////////////////////////////
// A channel driver
//////////////////////////////////////////////////

task automatic send_request(input string name, input logic [2:0] opcode,
	input logic [31:0] addr, input logic [7:0] size, input logic [7:0] mask,
	input logic [63:0] data, input logic [2:0] source, output bit taken);
	int waited;
	@(negedge clk);
	a_valid   = 1'b1;
	a_opcode  = opcode;
	a_address = addr;
	a_size    = size;
	a_mask    = mask;
	a_data    = data;
	a_source  = source;
	waited    = 0;
	while (!a_ready && waited < 16) begin // Slave may still be busy
		@(negedge clk);
		waited++;
	end
	taken = a_ready;
	if (!taken) begin
		report_failure($sformatf("%s request was never accepted", name));
		a_valid = 1'b0;
	end else begin
		@(posedge clk); // Beat transfers on this edge
	end
endtask

//////////////////////////////////////////////////
// D channel receiver
//////////////////////////////////////////////////

task automatic collect_response(input string name, input int stall,
	output logic [14:0] fields, output logic [63:0] data, output bit got);
	int edges;
	edges = 0;
	do begin
		@(negedge clk);
		a_valid = 1'b0;
		edges++;
	end while (!d_valid && edges < 16);
	got = d_valid;
	if (!got) begin
		report_failure($sformatf("%s got no response on the D channel", name));
		return;
	end
	check_value({name, " latency"}, 64'd2, 64'(edges)); // Two edges after accept
	fields = {d_opcode, d_error, d_size, d_source};        // First sampled beat
	data   = d_data;
	check_value({name, " d_param"}, 64'd0, 64'(d_param));
	check_value({name, " d_sink"}, 64'd0, 64'(d_sink));
	check_value({name, " a_ready busy"}, 64'd0, 64'(a_ready));
	// Back-pressure, the beat must not move
	for (int i = 0; i < stall; i++) begin
		@(negedge clk);
		check_value({name, " d_valid held"}, 64'd1, 64'(d_valid));
		check_value({name, " a_ready held"}, 64'd0, 64'(a_ready));
		check_value({name, " fields held"}, 64'(fields),
			64'({d_opcode, d_error, d_size, d_source}));
		check_value({name, " d_data held"}, data, d_data);
	end
	d_ready = 1'b1;
	@(negedge clk);
	d_ready = 1'b0;
	check_value({name, " d_valid drop"}, 64'd0, 64'(d_valid));
	check_value({name, " a_ready back"}, 64'd1, 64'(a_ready));
endtask

`endif

// ==== sim/tl_ul_slave_tb.sv ====
`timescale 1ns/10ps

module tl_ul_slave_tb import tl_ul_pkg::*; ();

	localparam int depth        = 64;
	localparam int n_full       = 40;
	localparam int n_partial    = 40;
	localparam int n_error      = 24;
	localparam int n_stall      = 30;
	localparam int reset_cycles = 10;
	// Requests issued over all tests
	localparam int n_txn = depth + 2*n_full + 2*n_partial + 2*n_error + n_stall;

	logic                   clk, rst;
	logic                   a_valid, a_ready, d_valid, d_ready, d_error;
	logic [tl_opcode_w-1:0] a_opcode, d_opcode;
	logic [tl_param_w-1:0]  a_param, d_param;
	logic [tl_addr_w-1:0]   a_address;
	logic [tl_size_w-1:0]   a_size, d_size;
	logic [tl_strb_w-1:0]   a_mask;
	logic [tl_data_w-1:0]   a_data, d_data;
	logic [tl_source_w-1:0] a_source, d_source;
	logic [tl_sink_w-1:0]   d_sink;

	logic [31:0] lcg_state;
	int          pass_count;
	int          fail_count;
	logic [7:0]  model_mem [depth*8]; // Byte image of the slave memory

	`include "tl_ul_slave_tasks.svh"

	tl_ul_slave_top #(.DEPTH(depth)) UUT (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk; // 10 ns period

	// Watchdog, 40 cycles per request is far above the worst case
	initial begin
		#((n_txn * 40 + reset_cycles) * 10);
		$display("Watchdog expired, the tests did not complete in time");
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic model_access(input logic [2:0] opcode, input logic [31:0] addr,
		input logic [7:0] size, input logic [7:0] mask, input logic [63:0] data,
		output logic [14:0] fields, output logic [63:0] exp_data, input logic [2:0] source);
		int         base;
		logic [7:0] strb;
		logic       err;
		logic [2:0] d_op;
		err      = !(opcode == put_full_data || opcode == put_partial_data || opcode == get)
			|| size != 8'(tl_beat_size) || addr >= 32'(depth * 8);
		d_op     = (!err && opcode == get) ? 3'd1 : 3'd0; // AccessAckData only on get
		exp_data = '0;
		base     = int'(addr[8:3]) * 8;
		strb     = (opcode == put_full_data) ? 8'hFF : mask;
		for (int b = 0; b < 8; b++) begin
			if (!err && opcode == get)
				exp_data[8*b +: 8] = model_mem[base + b];
			else if (!err && strb[b])
				model_mem[base + b] = data[8*b +: 8];
		end
		fields = {d_op, err, size, source}; // Size and source echoed
	endtask

	// One request and its response, compared with the model
	task automatic run_txn(input string name, input logic [2:0] opcode,
		input logic [31:0] addr, input logic [7:0] size, input logic [7:0] mask,
		input logic [63:0] data, input int stall);
		logic [2:0]  source;
		logic [14:0] exp_fields, got_fields;
		logic [63:0] exp_data, got_data;
		bit          taken, got;
		source = 3'(rand_below(8));
		model_access(opcode, addr, size, mask, data, exp_fields, exp_data, source);
		send_request(name, opcode, addr, size, mask, data, source, taken);
		if (!taken)
			return;
		collect_response(name, stall, got_fields, got_data, got);
		if (!got)
			return;
		check_value({name, " opcode error size source"}, 64'(exp_fields), 64'(got_fields));
		check_value({name, " d_data"}, exp_data, got_data);
	endtask

	task automatic end_test(input string name, input int fails_before);
		$display("%s finished with %0d errors", name, fail_count - fails_before);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		int          fails_before;
		int          k;
		logic [31:0] addr;
		logic [7:0]  size;
		logic [2:0]  op;
		rst = 1'b1;
		a_valid = 1'b0;
		a_opcode = '0;
		a_param = '0; // Reserved field, stays zero
		a_address = '0;
		a_size = '0;
		a_mask = '0;
		a_data = '0;
		a_source = '0;
		d_ready = 1'b0;
		lcg_state = 32'd66801;
		pass_count = 0;
		fail_count = 0;
		for (int i = 0; i < depth*8; i++)
			model_mem[i] = 8'h00;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;

		// Clean state and clear memory
		fails_before = fail_count;
		@(negedge clk);
		check_value("reset a_ready", 64'd1, 64'(a_ready));
		check_value("reset d_valid", 64'd0, 64'(d_valid));
		for (int w = 0; w < depth; w++)
			run_txn("reset get", get, 32'(w * 8), 8'd3, 8'hFF, 64'd0, 0);
		end_test("Reset and clear read", fails_before);

		// Full puts, mask is ignored
		fails_before = fail_count;
		for (int i = 0; i < n_full; i++) begin
			addr = 32'(rand_below(depth) * 8);
			run_txn("full put", put_full_data, addr, 8'd3, 8'(rand_below(256)),
				{lcg_next(), lcg_next()}, 0);
			run_txn("full readback", get, addr, 8'd3, 8'hFF, 64'd0, 0);
		end
		end_test("PutFullData", fails_before);

		// Partial puts
		fails_before = fail_count;
		for (int i = 0; i < n_partial; i++) begin
			addr = 32'(rand_below(depth) * 8);
			run_txn("partial put", put_partial_data, addr, 8'd3, 8'(rand_below(256)),
				{lcg_next(), lcg_next()}, 0);
			run_txn("partial readback", get, addr, 8'd3, 8'hFF, 64'd0, 0);
		end
		end_test("PutPartialData", fails_before);

		// Bad opcode, bad size, out of range
		fails_before = fail_count;
		for (int i = 0; i < n_error; i++) begin
			addr = 32'(rand_below(depth) * 8);
			size = 8'd3;
			op   = put_full_data;
			k    = rand_below(3);
			if (k == 0) begin
				k  = rand_below(5);
				op = (k < 2) ? 3'(k + 2) : 3'(k + 3); // 2, 3, 5, 6 or 7
			end else if (k == 1) begin
				size = 8'(rand_below(255));
				if (size >= 8'd3)
					size = size + 8'd1; // Skip the one legal size
			end else begin
				addr = lcg_next() & 32'hFFFF_FFF8;
				if (addr < 32'(depth * 8))
					addr = addr | 32'h0000_0200; // Just past the last word
			end
			run_txn("error request", op, addr, size, 8'hFF, {lcg_next(), lcg_next()}, 0);
			run_txn("error readback", get, {23'd0, addr[8:3], 3'd0}, 8'd3, 8'hFF, 64'd0, 0);
		end
		end_test("Error responses", fails_before);

		// Mixed traffic under random back-pressure
		fails_before = fail_count;
		for (int i = 0; i < n_stall; i++) begin
			k = rand_below(3);
			if (k == 0)
				op = put_full_data;
			else if (k == 1)
				op = put_partial_data;
			else
				op = get;
			run_txn("stall", op, 32'(rand_below(depth) * 8), 8'd3, 8'(rand_below(256)),
				{lcg_next(), lcg_next()}, rand_below(8));
		end
		end_test("Back-pressure", fails_before);

		$display("Checks passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== logic/tl_ul_slave_top.sv ====
`timescale 1ns/10ps

module tl_ul_slave_top import tl_ul_pkg::*; #(
	parameter int DEPTH = 64 // Memory words
) (
	input  logic                   clk,
	input  logic                   rst,

	// A channel, master to slave
	input  logic                   a_valid,
	output logic                   a_ready,
	input  logic [tl_opcode_w-1:0] a_opcode,
	input  logic [tl_param_w-1:0]  a_param,   // Reserved, ignored
	input  logic [tl_addr_w-1:0]   a_address,
	input  logic [tl_size_w-1:0]   a_size,
	input  logic [tl_strb_w-1:0]   a_mask,
	input  logic [tl_data_w-1:0]   a_data,
	input  logic [tl_source_w-1:0] a_source,

	// D channel, slave to master
	output logic                   d_valid,
	input  logic                   d_ready,
	output logic [tl_opcode_w-1:0] d_opcode,
	output logic [tl_param_w-1:0]  d_param,
	output logic [tl_size_w-1:0]   d_size,
	output logic [tl_sink_w-1:0]   d_sink,
	output logic [tl_source_w-1:0] d_source,
	output logic [tl_data_w-1:0]   d_data,
	output logic                   d_error
);

	// FSM strobes
	logic capture;
	logic access;

	// Memory port
	logic                     mem_wen;
	logic [$clog2(DEPTH)-1:0] mem_index;
	logic [tl_strb_w-1:0]     mem_strb;
	logic [tl_data_w-1:0]     mem_wdata;
	logic [tl_data_w-1:0]     mem_rdata;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	tl_slave_fsm u_fsm (
		.clk     (clk),
		.rst     (rst),
		.a_valid (a_valid),
		.d_ready (d_ready),
		.a_ready (a_ready),
		.d_valid (d_valid),
		.capture (capture),
		.access  (access)
	);

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	tl_request_decode #(.DEPTH(DEPTH)) u_decode (
		.clk       (clk),
		.rst       (rst),
		.capture   (capture),
		.access    (access),
		.a_opcode  (a_opcode),
		.a_address (a_address),
		.a_size    (a_size),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.a_source  (a_source),
		.mem_rdata (mem_rdata),
		.mem_wen   (mem_wen),
		.mem_index (mem_index),
		.mem_strb  (mem_strb),
		.mem_wdata (mem_wdata),
		.d_opcode  (d_opcode),
		.d_param   (d_param),
		.d_size    (d_size),
		.d_sink    (d_sink),
		.d_source  (d_source),
		.d_data    (d_data),
		.d_error   (d_error)
	);

	tl_byte_mem #(.DEPTH(DEPTH)) u_mem (
		.clk   (clk),
		.rst   (rst),
		.wen   (mem_wen),
		.index (mem_index),
		.strb  (mem_strb),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

endmodule

// ==== logic/tl_byte_mem.sv ====
`timescale 1ns/10ps

module tl_byte_mem import tl_ul_pkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     wen,
	input  logic [$clog2(DEPTH)-1:0] index,
	input  logic [tl_strb_w-1:0]     strb,  // Byte enables
	input  logic [tl_data_w-1:0]     wdata,

	output logic [tl_data_w-1:0]     rdata  // Registered read
);

	logic [tl_data_w-1:0] mem [DEPTH];
	logic [tl_data_w-1:0] rdata_q;

	//////////////////////////////////////////////////
	// Storage with byte-masked write
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int w = 0; w < DEPTH; w++) begin
				mem[w] <= '0; // Memory starts clear
			end
		end else if (wen) begin
			for (int b = 0; b < tl_strb_w; b++) begin
				if (strb[b])
					mem[index][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////

	// Same edge as the write, so old contents come out
	always_ff @(posedge clk) begin
		rdata_q <= mem[index];
	end

	assign rdata = rdata_q;

endmodule

// ==== logic/tl_request_decode.sv ====
`timescale 1ns/10ps

module tl_request_decode import tl_ul_pkg::*; #(
	parameter int DEPTH = 64
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       capture,
	input  logic                       access,

	// A channel fields, sampled on capture
	input  logic [tl_opcode_w-1:0]     a_opcode,
	input  logic [tl_addr_w-1:0]       a_address,
	input  logic [tl_size_w-1:0]       a_size,
	input  logic [tl_strb_w-1:0]       a_mask,
	input  logic [tl_data_w-1:0]       a_data,
	input  logic [tl_source_w-1:0]     a_source,

	// Memory side
	input  logic [tl_data_w-1:0]       mem_rdata,
	output logic                       mem_wen,
	output logic [$clog2(DEPTH)-1:0]   mem_index,
	output logic [tl_strb_w-1:0]       mem_strb,
	output logic [tl_data_w-1:0]       mem_wdata,

	// D channel fields
	output logic [tl_opcode_w-1:0]     d_opcode,
	output logic [tl_param_w-1:0]      d_param,
	output logic [tl_size_w-1:0]       d_size,
	output logic [tl_sink_w-1:0]       d_sink,
	output logic [tl_source_w-1:0]     d_source,
	output logic [tl_data_w-1:0]       d_data,
	output logic                       d_error
);

	localparam int idx_w  = $clog2(DEPTH);
	localparam int idx_lo = tl_beat_size; // Byte offset bits below

	// Captured request
	logic [tl_opcode_w-1:0] opcode_q;
	logic [tl_addr_w-1:0]   addr_q;
	logic [tl_size_w-1:0]   size_q;
	logic [tl_strb_w-1:0]   mask_q;
	logic [tl_data_w-1:0]   data_q;
	logic [tl_source_w-1:0] source_q;

	logic is_full, is_partial, is_get;
	logic good_size, in_range;
	logic good_put, good_get;
	logic resp_get; // Registered good_get, selects read data

	//////////////////////////////////////////////////
	// Request register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (capture) begin
			opcode_q <= a_opcode;
			addr_q   <= a_address;
			size_q   <= a_size;
			mask_q   <= a_mask;
			data_q   <= a_data;
			source_q <= a_source;
		end
	end

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	assign is_full    = (opcode_q == put_full_data);
	assign is_partial = (opcode_q == put_partial_data);
	assign is_get     = (opcode_q == get);
	assign good_size  = (size_q == tl_size_w'(tl_beat_size)); // One full beat only

	assign mem_index = addr_q[idx_lo +: idx_w];
	// Nothing above the word index, and below DEPTH for odd sizes
	assign in_range  = (addr_q[tl_addr_w-1:idx_lo+idx_w] == '0) && (int'(mem_index) < DEPTH);

	assign good_put = (is_full | is_partial) & good_size & in_range;
	assign good_get = is_get & good_size & in_range;

	assign mem_wen   = access & good_put; // Errors never touch memory
	assign mem_strb  = is_full ? '1 : mask_q;
	assign mem_wdata = data_q;

	//////////////////////////////////////////////////
	// Response, loaded at the end of access
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resp_get <= 1'b0;
			d_error  <= 1'b0;
			d_opcode <= access_ack;
		end else if (access) begin
			resp_get <= good_get;
			d_error  <= ~(good_put | good_get);
			d_opcode <= good_get ? access_ack_data : access_ack; // Errors ack dataless
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			d_size   <= size_q;   // Echo
			d_source <= source_q; // Echo
		end
	end

	// Memory read register holds while responding
	assign d_data  = resp_get ? mem_rdata : '0;
	assign d_param = '0;
	assign d_sink  = '0;

	// Writes only in the cycle right after a request is taken
	a_wen_after_capture: assert property (
		@(posedge clk) disable iff (rst)
		mem_wen |-> access && $past(capture)
	);

endmodule

// ==== logic/tl_slave_fsm.sv ====
`timescale 1ns/10ps

module tl_slave_fsm import tl_ul_pkg::*; (
	input  logic clk,
	input  logic rst,

	// Handshake from the master
	input  logic a_valid,
	input  logic d_ready,

	// Handshake back to the master
	output logic a_ready,
	output logic d_valid,

	// Strobes into the datapath
	output logic capture, // Load the request register
	output logic access   // Single memory cycle
);

	slave_state_e state;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (a_valid) // a_ready is implied in idle
						state <= st_access;
				end
				st_access: begin
					state <= st_respond; // Always exactly one cycle
				end
				st_respond: begin
					// Hold the beat until the master takes it
					if (d_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs, pure decode of the state
	//////////////////////////////////////////////////

	assign a_ready = (state == st_idle);
	assign d_valid = (state == st_respond);
	assign access  = (state == st_access);
	assign capture = a_valid & a_ready; // A beat transfers here

	// One request in flight, so the channels never overlap
	a_no_overlap: assert property (
		@(posedge clk) disable iff (rst)
		!(d_valid && a_ready)
	);

	// A stalled response stays up until taken
	a_d_hold: assert property (
		@(posedge clk) disable iff (rst)
		d_valid && !d_ready |=> d_valid
	);

endmodule

// ==== logic/tl_ul_pkg.sv ====
package tl_ul_pkg;

	//////////////////////////////////////////////////
	// Channel field widths
	//////////////////////////////////////////////////

	parameter int tl_addr_w   = 32;            // Byte address
	parameter int tl_data_w   = 64;            // One beat of data
	parameter int tl_strb_w   = tl_data_w / 8; // One mask bit per byte
	parameter int tl_source_w = 3;             // Master tag, echoed on D
	parameter int tl_sink_w   = 3;             // Unused by this slave
	parameter int tl_opcode_w = 3;
	parameter int tl_param_w  = 3;             // Reserved, always zero
	parameter int tl_size_w   = 8;             // log2 of transfer bytes

	// Only a full single beat is served
	parameter int tl_beat_size = 3;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	// A channel, full encoding kept for decode
	typedef enum logic [tl_opcode_w-1:0] {
		put_full_data    = 3'd0,
		put_partial_data = 3'd1,
		arithmetic_data  = 3'd2, // Not served
		logical_data     = 3'd3, // Not served
		get              = 3'd4,
		intent           = 3'd5, // Not served
		acquire_block    = 3'd6, // TL-C only
		acquire_perm     = 3'd7  // TL-C only
	} a_opcode_e;

	// D channel, the two responses this slave sends
	typedef enum logic [tl_opcode_w-1:0] {
		access_ack      = 3'd0,
		access_ack_data = 3'd1
	} d_opcode_e;

	// Slave control FSM
	typedef enum logic [1:0] {
		st_idle,    // a_ready high
		st_access,  // Memory cycle
		st_respond  // d_valid high until d_ready
	} slave_state_e;

endpackage
